//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP      := tb_rtg_audio
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)
FAIL_MSG := Test failures found

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- aux_audio_pacer.sv
////////////////////////////////////////////////////////////////////////////
// Aux audio pacing: one left and one right sample per tick.
// Left pops on the tick, right two clocks later; outputs change together
// three clocks after the tick. Samples are little-endian signed words.
// No ticks while aud_ena is low.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

module aux_audio_pacer #(
  parameter int tick_div = `AUD_TICK_DIV_DEFAULT   // Clocks per tick
) (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           aud_ena,
  input  rtg_pkg::word_t sample,        // Stream head
  output logic           sample_pop,
  output rtg_pkg::word_t aud_l,
  output rtg_pkg::word_t aud_r,
  output logic           aud_strobe     // New pair on outputs
);

  localparam int DIV_W = $clog2(tick_div);

  logic [DIV_W-1:0] div_ctr;
  logic             tick;
  logic [1:0]       tick_d;             // Tick delayed by 1 and 2
  rtg_pkg::word_t   left_hold;

  // Byte swap and flip sign for an unsigned DAC
  function automatic rtg_pkg::word_t to_dac(input rtg_pkg::word_t s);
    return {~s[7], s[6:0], s[15:8]};
  endfunction

  assign sample_pop = tick || tick_d[1];

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      div_ctr    <= '0;
      tick       <= 1'b0;
      tick_d     <= '0;
      aud_strobe <= 1'b0;
    end else begin
      tick_d     <= {tick_d[0], tick};
      aud_strobe <= tick_d[1];
      if (!aud_ena) begin
        div_ctr <= '0;
        tick    <= 1'b0;
      end else if (div_ctr == DIV_W'(tick_div - 1)) begin
        div_ctr <= '0;
        tick    <= 1'b1;
      end else begin
        div_ctr <= div_ctr + 1'b1;
        tick    <= 1'b0;
      end
    end
  end

  // Sample registers
  always_ff @(posedge clk_114) begin
    if (tick)
      left_hold <= to_dac(sample);
    if (tick_d[1]) begin
      aud_l <= left_hold;
      aud_r <= to_dac(sample);
    end
  end

endmodule

//--- mem_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Fixed-priority arbiter of two burst requesters onto one read port.
// Video wins a tie. One burst outstanding; the next grant waits for the
// last word. Memory returns exactly RTG_BURST_LEN words, no back-pressure.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

module mem_arbiter (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           vid_req,
  input  rtg_pkg::addr_t vid_addr,
  output logic           vid_grant,
  output logic           vid_fill_valid,
  input  logic           aud_req,
  input  rtg_pkg::addr_t aud_addr,
  output logic           aud_grant,
  output logic           aud_fill_valid,
  output rtg_pkg::word_t fill_data,     // Shared by both streams
  output logic           mem_req,       // One-cycle strobe
  output rtg_pkg::addr_t mem_addr,
  input  logic           mem_valid,
  input  rtg_pkg::word_t mem_rdata
);

  localparam int BURST  = `RTG_BURST_LEN;
  localparam int BEAT_W = (BURST > 1) ? $clog2(BURST) : 1;

  logic                busy;            // Burst in flight
  rtg_pkg::req_owner_t owner;           // Recorded at grant
  logic [BEAT_W-1:0]   beat_cnt;        // Words received so far
  logic                last_beat;

  assign vid_grant = !busy && vid_req;
  assign aud_grant = !busy && aud_req && !vid_req;
  assign mem_req   = vid_grant || aud_grant;
  assign mem_addr  = vid_req ? vid_addr : aud_addr;
  assign last_beat = mem_valid && (beat_cnt == BEAT_W'(BURST - 1));

  // Route returned words
  assign vid_fill_valid = mem_valid && (owner == rtg_pkg::OWN_VID);
  assign aud_fill_valid = mem_valid && (owner == rtg_pkg::OWN_AUD);
  assign fill_data      = mem_rdata;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      owner    <= rtg_pkg::OWN_VID;
      beat_cnt <= '0;
    end else if (mem_req) begin
      busy     <= 1'b1;
      owner    <= vid_grant ? rtg_pkg::OWN_VID : rtg_pkg::OWN_AUD;
      beat_cnt <= '0;
    end else if (mem_valid) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (last_beat)
        busy <= 1'b0;                   // Port free next cycle
    end
  end

  // Memory must stay silent between bursts
  a_no_stray_valid: assert property (@(posedge clk_114) disable iff (!rst_n)
    !busy |-> !mem_valid);

endmodule

//--- rtg_audio_top.sv
////////////////////////////////////////////////////////////////////////////
// RTG video and aux audio fetch, sharing one memory read port.
// Blanking comes from the native timing generator on clk_114.
// Memory answers each mem_req with RTG_BURST_LEN words from mem_addr up.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

module rtg_audio_top #(
  parameter int aud_tick_div = `AUD_TICK_DIV_DEFAULT
) (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           rtg_ena,
  input  logic           rtg_16bit,
  input  rtg_pkg::pixw_t pixel_width,
  input  rtg_pkg::addr_t rtg_base,
  input  logic           hblank,
  input  logic           vblank,
  input  rtg_pkg::rgb8_t native_r,
  input  rtg_pkg::rgb8_t native_g,
  input  rtg_pkg::rgb8_t native_b,
  input  logic           aud_ena,
  input  rtg_pkg::addr_t aud_base,
  output logic           mem_req,
  output rtg_pkg::addr_t mem_addr,
  input  logic           mem_valid,
  input  rtg_pkg::word_t mem_rdata,
  output rtg_pkg::rgb8_t vid_r,
  output rtg_pkg::rgb8_t vid_g,
  output rtg_pkg::rgb8_t vid_b,
  output logic           vid_pixel,
  output rtg_pkg::word_t aud_l,
  output rtg_pkg::word_t aud_r,
  output logic           aud_strobe
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic           vid_req, vid_grant, vid_fill, vid_empty;
  logic           aud_req, aud_grant, aud_fill, aud_empty;
  rtg_pkg::addr_t vid_addr, aud_addr;
  rtg_pkg::word_t fill_data, vid_word, aud_word;
  logic           fetch_pixel, stream_clear, rtg_blank, aud_pop;

  ////////////////////////////////////////////////////////////////////////////
  // Video path
  ////////////////////////////////////////////////////////////////////////////

  rtg_pixel_timing u_timing (
    .clk_114(clk_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .hblank(hblank),
    .vblank(vblank), .pixel_width(pixel_width), .fetch_pixel(fetch_pixel),
    .stream_clear(stream_clear), .rtg_blank(rtg_blank));

  stream_prefetch u_vid_stream (
    .clk_114(clk_114), .rst_n(rst_n), .clear(stream_clear), .base_addr(rtg_base),
    .fetch_req(vid_req), .fetch_addr(vid_addr), .fetch_grant(vid_grant),
    .fill_valid(vid_fill), .fill_data(fill_data), .pop(fetch_pixel),
    .q(vid_word), .empty(vid_empty));    // empty left for debug taps

  rtg_color_expand u_expand (
    .clk_114(clk_114), .rst_n(rst_n), .rtg_ena(rtg_ena), .rtg_16bit(rtg_16bit),
    .rtg_blank(rtg_blank), .fetch_pixel(fetch_pixel), .pixel_word(vid_word),
    .native_r(native_r), .native_g(native_g), .native_b(native_b),
    .vid_r(vid_r), .vid_g(vid_g), .vid_b(vid_b), .vid_pixel(vid_pixel));

  ////////////////////////////////////////////////////////////////////////////
  // Audio path and shared port
  ////////////////////////////////////////////////////////////////////////////

  stream_prefetch u_aud_stream (
    .clk_114(clk_114), .rst_n(rst_n), .clear(!aud_ena), .base_addr(aud_base),
    .fetch_req(aud_req), .fetch_addr(aud_addr), .fetch_grant(aud_grant),
    .fill_valid(aud_fill), .fill_data(fill_data), .pop(aud_pop),
    .q(aud_word), .empty(aud_empty));

  aux_audio_pacer #(.tick_div(aud_tick_div)) u_pacer (
    .clk_114(clk_114), .rst_n(rst_n), .aud_ena(aud_ena), .sample(aud_word),
    .sample_pop(aud_pop), .aud_l(aud_l), .aud_r(aud_r), .aud_strobe(aud_strobe));

  mem_arbiter u_arb (
    .clk_114(clk_114), .rst_n(rst_n),
    .vid_req(vid_req), .vid_addr(vid_addr), .vid_grant(vid_grant),
    .vid_fill_valid(vid_fill),
    .aud_req(aud_req), .aud_addr(aud_addr), .aud_grant(aud_grant),
    .aud_fill_valid(aud_fill), .fill_data(fill_data),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_valid(mem_valid),
    .mem_rdata(mem_rdata));

  // A pixel fetch once the stream has data must find it ready
  a_vid_ahead: assert property (@(posedge clk_114) disable iff (!rst_n)
    (rtg_ena && !vid_empty && !stream_clear) ##1 fetch_pixel |-> !vid_empty || vid_fill);

  // Audio sample pops must find the stream primed
  a_aud_primed: assert property (@(posedge clk_114) disable iff (!rst_n)
    aud_pop && aud_ena |-> !aud_empty);

endmodule

//--- rtg_color_expand.sv
////////////////////////////////////////////////////////////////////////////
// Hi-colour to RGB888, registered one clock after the fetch strobe.
// 16-bit mode is 5-6-5, 15-bit mode is x-5-5-5; low bits repeat the MSBs.
// Native colour passes while RTG is off or blanked. vid_pixel is high
// every cycle with RTG off, as the native path runs at full rate.
////////////////////////////////////////////////////////////////////////////

module rtg_color_expand (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           rtg_ena,
  input  logic           rtg_16bit,     // 5-6-5 when set
  input  logic           rtg_blank,
  input  logic           fetch_pixel,
  input  rtg_pkg::word_t pixel_word,    // Stream head
  input  rtg_pkg::rgb8_t native_r,
  input  rtg_pkg::rgb8_t native_g,
  input  rtg_pkg::rgb8_t native_b,
  output rtg_pkg::rgb8_t vid_r,
  output rtg_pkg::rgb8_t vid_g,
  output rtg_pkg::rgb8_t vid_b,
  output logic           vid_pixel
);

  rtg_pkg::rgb8_t exp_r;
  rtg_pkg::rgb8_t exp_g;
  rtg_pkg::rgb8_t exp_b;

  assign exp_r = rtg_16bit ? {pixel_word[15:11], pixel_word[15:13]}
                           : {pixel_word[14:10], pixel_word[14:12]};
  assign exp_g = rtg_16bit ? {pixel_word[10:5], pixel_word[10:9]}
                           : {pixel_word[9:5], pixel_word[9:7]};
  assign exp_b = {pixel_word[4:0], pixel_word[4:2]};  // Same in both modes

  // Colour registers
  always_ff @(posedge clk_114) begin
    if (!rtg_ena || rtg_blank) begin
      vid_r <= native_r;
      vid_g <= native_g;
      vid_b <= native_b;
    end else if (fetch_pixel) begin
      vid_r <= exp_r;
      vid_g <= exp_g;
      vid_b <= exp_b;
    end
  end

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n)
      vid_pixel <= 1'b0;
    else
      vid_pixel <= rtg_ena ? fetch_pixel : 1'b1;
  end

endmodule

//--- rtg_defines.svh
////////////////////////////////////////////////////////////////////////////
// Shared widths and sizes for the RTG video and aux audio fetch path.
// RTG_FIFO_DEPTH and RTG_BURST_LEN must be powers of two, and the depth
// must be at least two bursts or the prefetch never gets ahead.
// AUD_TICK_DIV_DEFAULT gives about 44.6 kHz from a 114.75 MHz clock.
////////////////////////////////////////////////////////////////////////////

`ifndef RTG_DEFINES_SVH
`define RTG_DEFINES_SVH

// Memory side
`define RTG_ADDR_W 24          // Word address bits
`define RTG_WORD_W 16          // Memory word bits

// Prefetch FIFO
`define RTG_FIFO_DEPTH 16      // Words per stream
`define RTG_BURST_LEN 4        // Words per memory burst

// Pixel pacing
`define RTG_PIXW_W 4           // Clocks-per-pixel field

// Audio pacing
`define AUD_TICK_DIV_DEFAULT 2572 // Clocks per stereo tick

`endif

//--- rtg_pixel_timing.sv
////////////////////////////////////////////////////////////////////////////
// RTG pixel pacing from native blanking.
// Fetch strobe every pixel_width+1 clocks in active video; counter held
// at zero in blanking. The stream is restarted on the first vblank clock
// and held clear while RTG is off, leaving the rest of vblank to prefetch.
////////////////////////////////////////////////////////////////////////////

module rtg_pixel_timing (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           rtg_ena,
  input  logic           hblank,
  input  logic           vblank,
  input  rtg_pkg::pixw_t pixel_width,   // Clocks per pixel minus one
  output logic           fetch_pixel,   // Pop the next pixel
  output logic           stream_clear,
  output logic           rtg_blank
);

  rtg_pkg::pixw_t pixel_ctr;
  logic           vblank_d;

  assign rtg_blank    = hblank || vblank;
  assign fetch_pixel  = rtg_ena && !rtg_blank && (pixel_ctr == pixel_width);
  assign stream_clear = !rtg_ena || (vblank && !vblank_d);  // Frame restart

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      pixel_ctr <= '0;
      vblank_d  <= 1'b0;
    end else begin
      vblank_d <= vblank;
      if (!rtg_ena || rtg_blank || fetch_pixel)
        pixel_ctr <= '0;                // Restart each pixel
      else
        pixel_ctr <= pixel_ctr + 1'b1;
    end
  end

endmodule

//--- rtg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Types shared by the RTG and aux audio fetch blocks.
// Widths come from rtg_defines.svh; change them there only.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

package rtg_pkg;

  // One memory word, pixel or audio sample
  typedef logic [`RTG_WORD_W-1:0] word_t;

  // Word address into external memory
  typedef logic [`RTG_ADDR_W-1:0] addr_t;

  // One colour channel at the output
  typedef logic [7:0] rgb8_t;

  // Clocks per pixel minus one
  typedef logic [`RTG_PIXW_W-1:0] pixw_t;

  // Which requester holds the memory port
  typedef enum logic {
    OWN_VID = 1'b0,           // Video stream
    OWN_AUD = 1'b1            // Audio stream
  } req_owner_t;

endpackage

//--- sim.f
+incdir+.
rtg_pkg.sv
stream_prefetch.sv
mem_arbiter.sv
rtg_pixel_timing.sv
rtg_color_expand.sv
aux_audio_pacer.sv
rtg_audio_top.sv
tb_mem_model.sv
tb_rtg_audio.sv

//--- stream_prefetch.sv
////////////////////////////////////////////////////////////////////////////
// Sequential-address prefetch FIFO with show-ahead output.
// Requests a burst once the free space, less words still owed, fits one.
// Clear empties the FIFO and reloads base_addr; owed words of a burst in
// flight are dropped on arrival. Pop on empty is ignored.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

module stream_prefetch (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           clear,        // Restart at base
  input  rtg_pkg::addr_t base_addr,
  output logic           fetch_req,    // Held until grant
  output rtg_pkg::addr_t fetch_addr,
  input  logic           fetch_grant,
  input  logic           fill_valid,
  input  rtg_pkg::word_t fill_data,
  input  logic           pop,          // Consume head word
  output rtg_pkg::word_t q,            // Head word, show-ahead
  output logic           empty
);

  localparam int DEPTH = `RTG_FIFO_DEPTH;
  localparam int BURST = `RTG_BURST_LEN;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  rtg_pkg::word_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;             // Words held
  logic [CNT_W-1:0] owed;              // Words still to arrive
  logic [CNT_W-1:0] drop;              // Owed words to discard
  logic [CNT_W-1:0] owed_nxt;
  logic             req_q;
  rtg_pkg::addr_t   addr_q;            // Next burst address
  logic             grant_hit;
  logic             fill_hit;
  logic             wr_en;
  logic             rd_en;
  logic             room;

  assign grant_hit = fetch_grant && req_q;
  assign fill_hit  = fill_valid && (owed != '0);  // Stray words ignored
  assign wr_en     = fill_hit && (drop == '0) && !clear;
  assign rd_en     = pop && (count != '0) && !clear;
  assign room      = (int'(count) + int'(owed) + BURST) <= DEPTH;

  assign owed_nxt = owed + (grant_hit ? CNT_W'(BURST) : '0) - (fill_hit ? CNT_W'(1) : '0);

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      owed   <= '0;
      drop   <= '0;
      req_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      owed <= owed_nxt;                // Tracked through clear too
      if (clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        req_q  <= 1'b0;
        addr_q <= base_addr;
        drop   <= owed_nxt;            // Flush the burst in flight
      end else begin
        if (fill_hit && (drop != '0))
          drop <= drop - 1'b1;
        if (wr_en)
          wr_ptr <= wr_ptr + 1'b1;
        if (rd_en)
          rd_ptr <= rd_ptr + 1'b1;
        count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        if (grant_hit) begin
          req_q  <= 1'b0;
          addr_q <= addr_q + rtg_pkg::addr_t'(BURST);
        end else if (!req_q && room) begin
          req_q <= 1'b1;               // Whole burst fits
        end
      end
    end
  end

  // Storage
  always_ff @(posedge clk_114) begin
    if (wr_en)
      mem[wr_ptr] <= fill_data;
  end

  assign q          = mem[rd_ptr];
  assign empty      = (count == '0);
  assign fetch_req  = req_q;
  assign fetch_addr = addr_q;

  // Arbiter and memory keep within the space reserved at request time
  a_no_overflow: assert property (@(posedge clk_114) disable iff (!rst_n)
    wr_en |-> (count != CNT_W'(DEPTH)) || rd_en);

  a_req_hold: assert property (@(posedge clk_114) disable iff (!rst_n)
    (fetch_req && !fetch_grant && !clear) |=> fetch_req && $stable(fetch_addr));

endmodule

//--- tb_mem_model.sv
////////////////////////////////////////////////////////////////////////////
// Memory responder for the shared read port of the RTG audio top.
// Each mem_req gets RTG_BURST_LEN words from mem_addr up. Each word is
// the low address half XOR 5a5a, 1 to 8 clocks apart, gap from an LFSR.
// Works on falling edges and serves one burst at a time.
////////////////////////////////////////////////////////////////////////////

`include "rtg_defines.svh"

module tb_mem_model (
  input  logic           clk_114,
  input  logic           rst_n,
  input  logic           mem_req,       // One-cycle strobe from arbiter
  input  rtg_pkg::addr_t mem_addr,
  output logic           mem_valid,
  output rtg_pkg::word_t mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lfsr = 32'he449c11c;     // Latency generator state

  // Fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  initial begin : respond
    rtg_pkg::addr_t addr;
    int             gap;
    mem_valid = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clk_114);
      mem_valid = 1'b0;                 // Port idle between bursts
      if (rst_n && mem_req) begin
        addr = mem_addr;
        for (int beat = 0; beat < `RTG_BURST_LEN; beat++) begin
          gap = 1 + int'(take_bits(3));   // 1 to 8 clocks
          @(negedge clk_114);
          mem_valid = 1'b0;
          repeat (gap - 1) @(negedge clk_114);
          mem_valid = 1'b1;
          mem_rdata = addr[15:0] ^ 16'h5a5a;
          addr      = addr + 1'b1;       // Consecutive words
        end
      end
    end
  end

endmodule

//--- tb_rtg_audio.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the RTG video and aux audio fetch top level.
// Inputs change on falling edges, outputs are sampled there as well.
// Memory data is the low address half XOR 5a5a, so every expected pixel
// and sample follows from its address. Audio tick is 40 clocks.
////////////////////////////////////////////////////////////////////////////

module tb_rtg_audio;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AUD_DIV  = 40;         // Clocks per stereo tick
  localparam int WAIT_MAX = 400;        // Clocks per wait before giving up

  logic           clk_114;
  logic           rst_n;
  logic           rtg_ena, rtg_16bit, hblank, vblank, aud_ena;
  rtg_pkg::pixw_t pixel_width;
  rtg_pkg::addr_t rtg_base, aud_base, mem_addr;
  rtg_pkg::rgb8_t native_r, native_g, native_b;
  rtg_pkg::rgb8_t vid_r, vid_g, vid_b;
  logic           mem_req, mem_valid, vid_pixel, aud_strobe;
  rtg_pkg::word_t mem_rdata, aud_l, aud_r;
  int             mismatches;           // Wrong values seen
  int             timeouts;             // Waits that ran out

  rtg_audio_top #(.aud_tick_div(AUD_DIV)) dut0 (.*);
  tb_mem_model mem0 (.*);

  initial begin
    clk_114 = 1'b0;
    forever #50 clk_114 = ~clk_114;     // 100 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic rtg_pkg::word_t mem_word(input rtg_pkg::addr_t a);
    return a[15:0] ^ 16'h5a5a;          // What the memory model holds
  endfunction

  function automatic rtg_pkg::word_t dac_word(input rtg_pkg::word_t s);
    rtg_pkg::word_t swapped;
    swapped = {s[7:0], s[15:8]};        // Little-endian sample
    return swapped ^ 16'h8000;          // Signed to unsigned
  endfunction

  // Field widening by MSB repeat, packed as r g b
  function automatic logic [23:0] pixel_rgb(input rtg_pkg::word_t w, input logic mode16);
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] g5;
    logic [4:0] b5;
    b5 = w[4:0];
    if (mode16) begin
      r5 = w[15:11];
      g6 = w[10:5];
      return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
    end
    r5 = w[14:10];                      // Bit 15 unused in 15-bit mode
    g5 = w[9:5];
    return {r5, r5[4:2], g5, g5[4:2], b5, b5[4:2]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic wait_pixel(input string name, output int gap, output bit ok);
    gap = 0;
    do begin
      @(negedge clk_114);
      gap++;
    end while (!vid_pixel && gap < WAIT_MAX);
    ok = vid_pixel;
    if (!ok) begin
      timeouts++;
      $display("%s: no vid_pixel pulse within %0d clocks", name, WAIT_MAX);
    end
  endtask

  task automatic wait_strobe(input string name, output bit ok);
    int clocks;
    clocks = 0;
    do begin
      @(negedge clk_114);
      clocks++;
    end while (!aud_strobe && clocks < WAIT_MAX);
    ok = aud_strobe;
    if (!ok) begin
      timeouts++;
      $display("%s: no aud_strobe pulse within %0d clocks", name, WAIT_MAX);
    end
  endtask

  // Vblank pulse restarts the stream and lets it prefetch
  task automatic start_frame(input int clocks);
    hblank = 1'b0;
    vblank = 1'b1;
    repeat (clocks) @(negedge clk_114);
    vblank = 1'b0;
  endtask

  task automatic expect_pixels(input string name, input rtg_pkg::addr_t base,
                               input logic mode16, input int count, input int spacing);
    int          gap;
    bit          ok;
    logic [23:0] exp_rgb;
    for (int k = 0; k < count; k++) begin
      wait_pixel(name, gap, ok);
      if (!ok)
        return;                         // Rest of the frame is lost
      exp_rgb = pixel_rgb(mem_word(base + rtg_pkg::addr_t'(k)), mode16);
      check_value($sformatf("%s pixel %0d", name, k), 32'(exp_rgb),
                  32'({vid_r, vid_g, vid_b}));
      if (spacing > 0 && k > 0)
        check_value($sformatf("%s spacing %0d", name, k), 32'(spacing), 32'(gap));
    end
  endtask

  task automatic expect_samples(input string name, input rtg_pkg::addr_t base,
                                input int pairs);
    bit             ok;
    rtg_pkg::addr_t a;
    for (int k = 0; k < pairs; k++) begin
      wait_strobe(name, ok);
      if (!ok)
        return;
      a = base + rtg_pkg::addr_t'(2 * k);   // Left then right in memory
      check_value($sformatf("%s left %0d", name, k), 32'(dac_word(mem_word(a))), 32'(aud_l));
      check_value($sformatf("%s right %0d", name, k),
                  32'(dac_word(mem_word(a + 24'd1))), 32'(aud_r));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    check_value("reset mem_req", 32'd0, 32'(mem_req));   // Still reset values
    check_value("reset vid_pixel", 32'd0, 32'(vid_pixel));
    check_value("reset aud_strobe", 32'd0, 32'(aud_strobe));
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_114);
      check_value("idle mem_req", 32'd0, 32'(mem_req));
      check_value("idle aud_strobe", 32'd0, 32'(aud_strobe));
      check_value("idle vid_pixel", 32'd1, 32'(vid_pixel));  // Native rate
      check_value("idle rgb", 32'({native_r, native_g, native_b}),
                  32'({vid_r, vid_g, vid_b}));
    end
  endtask

  task automatic rtg_15bit_frame();
    rtg_16bit   = 1'b0;
    pixel_width = 4'd11;
    rtg_base    = 24'h001000;
    rtg_ena     = 1'b1;
    start_frame(200);
    expect_pixels("rtg15", rtg_base, 1'b0, 20, 0);
  endtask

  task automatic rtg_16bit_frame();
    rtg_16bit   = 1'b1;
    pixel_width = 4'd15;
    rtg_base    = 24'h0a3c40;
    start_frame(200);
    expect_pixels("rtg16", rtg_base, 1'b1, 20, 16);
  endtask

  task automatic blanking_passthrough();
    native_r = 8'hc3;
    native_g = 8'h3c;
    native_b = 8'h99;
    hblank   = 1'b1;
    repeat (2) @(negedge clk_114);
    for (int i = 0; i < 8; i++) begin
      check_value("hblank rgb", 32'({native_r, native_g, native_b}),
                  32'({vid_r, vid_g, vid_b}));
      check_value("hblank vid_pixel", 32'd0, 32'(vid_pixel));
      @(negedge clk_114);
    end
    hblank = 1'b0;
    repeat (40) @(negedge clk_114);     // A few pixels mid-line
    start_frame(200);
    expect_pixels("vblank restart", rtg_base, 1'b1, 8, 16);
    rtg_ena = 1'b0;
  endtask

  task automatic audio_pairs();
    aud_base = 24'h020100;
    repeat (40) @(negedge clk_114);     // Video burst drains and base loads under clear
    aud_ena  = 1'b1;
    expect_samples("audio", aud_base, 8);
    aud_ena = 1'b0;
    repeat (4) @(negedge clk_114);
  endtask

  // Audio primes first so video priority cannot starve it
  task automatic shared_port_traffic();
    aud_base = 24'h031ff8;
    @(negedge clk_114);                 // Base loads under clear
    aud_ena  = 1'b1;
    fork
      expect_samples("shared audio", aud_base, 24);
      begin
        repeat (200) @(negedge clk_114);
        rtg_16bit   = 1'b1;
        pixel_width = 4'd15;
        rtg_base    = 24'h047ffc;
        rtg_ena     = 1'b1;
        start_frame(300);
        expect_pixels("shared video", rtg_base, 1'b1, 24, 16);
      end
    join
    aud_ena = 1'b0;
    rtg_ena = 1'b0;
  endtask

  initial begin
    mismatches  = 0;
    timeouts    = 0;
    rst_n       = 1'b0;
    rtg_ena     = 1'b0;
    rtg_16bit   = 1'b0;
    pixel_width = '0;
    rtg_base    = '0;
    hblank      = 1'b0;
    vblank      = 1'b0;
    native_r    = 8'h12;
    native_g    = 8'h34;
    native_b    = 8'h56;
    aud_ena     = 1'b0;
    aud_base    = '0;
    repeat (16) @(negedge clk_114);
    rst_n = 1'b1;
    idle_after_reset();
    rtg_15bit_frame();
    rtg_16bit_frame();
    blanking_passthrough();
    audio_pairs();
    shared_port_traffic();
    $display("Done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
